// File: sim.f
design/icache_pkg.sv
design/icache_lookup.sv
design/icache_refill.sv
design/icache_top.sv
verification/tb_clock_gen.sv
verification/tb_apb_memory.sv
verification/icache_checker.sv
verification/tb_icache.sv

// File: verification/tb_icache.sv
`timescale 1ns/1ps

module tb_icache
  import icache_pkg::*;
();

  localparam logic [xlen-1:0] mem_pattern = 32'hc3a5_96e1;
  localparam logic [xlen-1:0] err_base = 32'hf000_0000;  // Bus error from here upwards
  localparam int unsigned seed = 32'h3b97_2087;
  localparam int reset_timeout = 40;
  localparam int ready_timeout = 50;
  localparam int resp_timeout = 200;  // Enough for two line fetches with stalls

  typedef enum logic [1:0] {exp_hit, exp_miss, exp_error} fetch_class_e;

  typedef struct {
    string           name;
    logic            use_0;
    logic            use_1;
    logic [xlen-1:0] addr_0;
    logic [xlen-1:0] addr_1;
    fetch_class_e    cls;
    int              refills;  // Whole lines read over APB
  } fetch_entry_t;

  logic            global_bus;
  logic            rst;
  logic            req_0;
  logic [xlen-1:0] addr_0;
  logic            ready_0;
  logic            resp_valid_0;
  logic [xlen-1:0] instr_0;
  logic            resp_err_0;
  logic            req_1;
  logic [xlen-1:0] addr_1;
  logic            ready_1;
  logic            resp_valid_1;
  logic [xlen-1:0] instr_1;
  logic            resp_err_1;
  logic            psel;
  logic            penable;
  logic [xlen-1:0] paddr;
  logic [xlen-1:0] prdata;
  logic            pready;
  logic            pslverr;

  fetch_entry_t    tests[$];
  logic [xlen-1:0] paddr_log[$];  // Address of every setup cycle in the current test
  int              errors = 0;
  int              timeouts = 0;

  tb_clock_gen i_clock_gen (.global_bus(global_bus), .rst(rst));

  tb_apb_memory #(.pattern(mem_pattern), .err_base(err_base), .seed(seed)) i_memory (
    .global_bus (global_bus),
    .psel       (psel),
    .penable    (penable),
    .paddr      (paddr),
    .prdata     (prdata),
    .pready     (pready),
    .pslverr    (pslverr)
  );

  icache_top i_icache_top (
    .global_bus   (global_bus),
    .rst          (rst),
    .req_0        (req_0),
    .addr_0       (addr_0),
    .ready_0      (ready_0),
    .resp_valid_0 (resp_valid_0),
    .instr_0      (instr_0),
    .resp_err_0   (resp_err_0),
    .req_1        (req_1),
    .addr_1       (addr_1),
    .ready_1      (ready_1),
    .resp_valid_1 (resp_valid_1),
    .instr_1      (instr_1),
    .resp_err_1   (resp_err_1),
    .psel         (psel),
    .penable      (penable),
    .paddr        (paddr),
    .prdata       (prdata),
    .pready       (pready),
    .pslverr      (pslverr)
  );

  always @(negedge global_bus) begin
    if (psel && !penable) begin
      paddr_log.push_back(paddr);  // One setup cycle per APB transfer
    end
  end

  // **********************************************************
  // Expected values and compare tasks
  // **********************************************************

  function automatic logic [xlen-1:0] expected_word(input logic [xlen-1:0] a);
    return {a[xlen-1:2], 2'b00} ^ mem_pattern;  // Byte bits are ignored by the cache
  endfunction

  function automatic logic [xlen-1:0] line_base(input logic [xlen-1:0] a);
    return a & ~(xlen'(words * 4 - 1));
  endfunction

  task automatic check_word(input string name, input logic [xlen-1:0] expected,
                            input logic [xlen-1:0] actual);
    if (actual !== expected) begin
      $display("MISMATCH %s expected %h actual %h", name, expected, actual);
      errors++;
    end
  endtask

  task automatic check_flag(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("MISMATCH %s expected %b actual %b", name, expected, actual);
      errors++;
    end
  endtask

  task automatic check_count(input string name, input int expected, input int actual);
    if (actual != expected) begin
      $display("MISMATCH %s expected %0d actual %0d", name, expected, actual);
      errors++;
    end
  endtask

  // **********************************************************
  // Port driving
  // **********************************************************

  task automatic drive_port(input int port, input logic value, input logic [xlen-1:0] a);
    if (port == 0) begin
      req_0  <= value;
      addr_0 <= a;
    end else begin
      req_1  <= value;
      addr_1 <= a;
    end
  endtask

  task automatic fetch(input int port, input logic [xlen-1:0] a, output logic [xlen-1:0] word,
                       output logic err, output int lat);
    int   waited;
    logic seen;
    word   = '0;
    err    = 1'b0;
    lat    = 0;
    waited = 0;
    seen   = 1'b0;
    @(posedge global_bus);
    drive_port(port, 1'b1, a);
    @(negedge global_bus);
    while (!((port == 0) ? ready_0 : ready_1) && (waited < ready_timeout)) begin
      @(negedge global_bus);
      waited++;
    end
    if (!((port == 0) ? ready_0 : ready_1)) begin
      $display("Port %0d stayed busy for %0d cycles before address %h", port, waited, a);
      timeouts++;
      return;
    end
    @(posedge global_bus);  // Request taken on this edge
    drive_port(port, 1'b0, a);
    while (!seen && (lat < resp_timeout)) begin
      @(posedge global_bus);
      lat++;
      @(negedge global_bus);
      seen = (port == 0) ? resp_valid_0 : resp_valid_1;
    end
    if (!seen) begin
      $display("Port %0d gave no response for address %h within %0d cycles", port, a, lat);
      timeouts++;
      return;
    end
    word = (port == 0) ? instr_0 : instr_1;
    err  = (port == 0) ? resp_err_0 : resp_err_1;
  endtask

  // **********************************************************
  // Test table
  // **********************************************************

  task automatic add_entry(input string name, input logic use_0, input logic use_1,
                           input logic [xlen-1:0] a0, input logic [xlen-1:0] a1,
                           input fetch_class_e cls, input int refills);
    fetch_entry_t e;
    e.name    = name;
    e.use_0   = use_0;
    e.use_1   = use_1;
    e.addr_0  = a0;
    e.addr_1  = a1;
    e.cls     = cls;
    e.refills = refills;
    tests.push_back(e);
  endtask

  task automatic build_table();
    //        name               p0    p1    addr_0        addr_1        class      lines
    add_entry("cold_miss_p0",    1'b1, 1'b0, 32'h0000_1004, 32'h0,       exp_miss,  1);
    add_entry("repeat_hit_p0",   1'b1, 1'b0, 32'h0000_1004, 32'h0,       exp_hit,   0);
    add_entry("line_hit_p0",     1'b1, 1'b0, 32'h0000_100c, 32'h0,       exp_hit,   0);
    add_entry("line_hit_p1",     1'b0, 1'b1, 32'h0,       32'h0000_1000, exp_hit,   0);
    add_entry("cold_miss_p1",    1'b0, 1'b1, 32'h0,       32'h0000_7060, exp_miss,  1);
    add_entry("dual_miss_diff",  1'b1, 1'b1, 32'h0000_2010, 32'h0000_3028, exp_miss, 2);
    add_entry("dual_hit",        1'b1, 1'b1, 32'h0000_2014, 32'h0000_302c, exp_hit,  0);
    add_entry("dual_miss_same",  1'b1, 1'b1, 32'h0000_4034, 32'h0000_4038, exp_miss, 1);
    add_entry("evict_a",         1'b1, 1'b0, 32'h0000_5040, 32'h0,       exp_miss,  1);
    add_entry("evict_b",         1'b1, 1'b0, 32'h0000_6040, 32'h0,       exp_miss,  1);
    add_entry("evict_a_again",   1'b0, 1'b1, 32'h0,       32'h0000_5044, exp_miss,  1);
    add_entry("evict_b_again",   1'b1, 1'b0, 32'h0000_6048, 32'h0,       exp_miss,  1);
    add_entry("bus_error",       1'b1, 1'b0, 32'hf000_0050, 32'h0,       exp_error, 1);
    add_entry("bus_error_again", 1'b0, 1'b1, 32'h0,       32'hf000_0050, exp_error, 1);
    add_entry("old_line_hit",    1'b1, 1'b0, 32'h0000_1008, 32'h0,       exp_hit,   0);
  endtask

  task automatic judge_response(input string name, input logic [xlen-1:0] a,
                                input fetch_class_e cls, input logic [xlen-1:0] word,
                                input logic err, input int lat);
    if (cls == exp_error) begin
      check_word({name, " instr"}, '0, word);
      check_flag({name, " resp_err"}, 1'b1, err);
    end else begin
      check_word({name, " instr"}, expected_word(a), word);
      check_flag({name, " resp_err"}, 1'b0, err);
    end
    if (cls == exp_hit) begin
      check_count({name, " latency"}, 1, lat);
    end else if (lat <= 1) begin
      $display("Test %s answered a miss after only %0d cycle", name, lat);
      errors++;
    end
  endtask

  task automatic audit_transfers(input fetch_entry_t e);
    logic [xlen-1:0] base;
    logic            known;
    check_count({e.name, " transfers"}, e.refills * words, paddr_log.size());
    for (int g = 0; g + words <= paddr_log.size(); g += words) begin
      base  = paddr_log[g];
      known = (e.use_0 && (base == line_base(e.addr_0))) ||
              (e.use_1 && (base == line_base(e.addr_1)));
      if (!known) begin
        $display("Test %s fetched a line at %h that no port asked for", e.name, base);
        errors++;
      end
      for (int w = 1; w < words; w++) begin
        check_word({e.name, " paddr"}, base + xlen'(4 * w), paddr_log[g + w]);
      end
    end
  endtask

  task automatic run_entry(input fetch_entry_t e);
    logic [xlen-1:0] word_0;
    logic [xlen-1:0] word_1;
    logic            err_0;
    logic            err_1;
    int              lat_0;
    int              lat_1;
    @(posedge global_bus);
    paddr_log.delete();
    fork
      if (e.use_0) fetch(0, e.addr_0, word_0, err_0, lat_0);
      if (e.use_1) fetch(1, e.addr_1, word_1, err_1, lat_1);
    join
    if (timeouts != 0) begin
      return;
    end
    if (e.use_0) begin
      judge_response({e.name, "_p0"}, e.addr_0, e.cls, word_0, err_0, lat_0);
    end
    if (e.use_1) begin
      judge_response({e.name, "_p1"}, e.addr_1, e.cls, word_1, err_1, lat_1);
    end
    audit_transfers(e);
  endtask

  // **********************************************************
  // Main sequence
  // **********************************************************

  initial begin
    int waited;
    int asserts;
    req_0  = 1'b0;
    addr_0 = '0;
    req_1  = 1'b0;
    addr_1 = '0;
    waited = 0;
    build_table();
    @(negedge global_bus);
    while (rst && (waited < reset_timeout)) begin
      @(negedge global_bus);
      waited++;
    end
    if (rst) begin
      $display("Reset was still asserted after %0d cycles", waited);
      timeouts++;
    end else begin
      check_flag("reset ready_0", 1'b1, ready_0);
      check_flag("reset ready_1", 1'b1, ready_1);
      check_flag("reset resp_valid_0", 1'b0, resp_valid_0);
      check_flag("reset resp_valid_1", 1'b0, resp_valid_1);
      check_flag("reset psel", 1'b0, psel);
      check_flag("reset penable", 1'b0, penable);
      foreach (tests[i]) begin
        if (timeouts == 0) begin
          run_entry(tests[i]);
        end
      end
    end
    asserts = i_icache_top.i_refill.i_checker.assert_fails;
    $display("Summary: %0d mismatches, %0d timeouts, %0d assertion failures",
             errors, timeouts, asserts);
    if ((errors == 0) && (timeouts == 0) && (asserts == 0)) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// File: verification/icache_checker.sv
`timescale 1ns/1ps

module icache_checker
  import icache_pkg::*;
(
  input logic            global_bus,
  input logic            rst,
  input logic            psel,
  input logic            penable,
  input logic            pready,
  input logic [xlen-1:0] paddr,
  input refill_state_e   state
);

  int assert_fails = 0;  // Number of failed assertions

  // **********************************************************
  // APB master protocol
  // **********************************************************

  a_psel_rise: assert property (@(posedge global_bus) disable iff (rst)
    $rose(psel) |-> !penable)
    else begin
      $error("psel rose together with penable");
      assert_fails++;
    end

  a_paddr_stable: assert property (@(posedge global_bus) disable iff (rst)
    (psel && !(penable && pready)) |=> $stable(paddr))
    else begin
      $error("paddr changed inside a transfer");
      assert_fails++;
    end

  a_penable_follows: assert property (@(posedge global_bus) disable iff (rst)
    (psel && !penable) |=> (psel && penable))
    else begin
      $error("penable did not follow the setup cycle");
      assert_fails++;
    end

  a_state_legal: assert property (@(posedge global_bus) disable iff (rst)
    !$isunknown(state) && (state inside {idle, setup, access, write_line}))
    else begin
      $error("refill engine left its legal states");
      assert_fails++;
    end

endmodule

bind icache_refill icache_checker i_checker (
  .global_bus (global_bus),
  .rst        (rst),
  .psel       (psel),
  .penable    (penable),
  .pready     (pready),
  .paddr      (paddr),
  .state      (state)
);

// File: verification/tb_apb_memory.sv
`timescale 1ns/1ps

module tb_apb_memory
  import icache_pkg::*;
#(
  parameter logic [xlen-1:0] pattern = '0,
  parameter logic [xlen-1:0] err_base = '1,
  parameter int unsigned seed = 1
)
(
  input  logic            global_bus,
  input  logic            psel,
  input  logic            penable,
  input  logic [xlen-1:0] paddr,
  output logic [xlen-1:0] prdata,
  output logic            pready,
  output logic            pslverr
);

  // **********************************************************
  // Read-only memory with wait states
  // **********************************************************

  logic [1:0] wait_left;  // Access cycles still to stall

  assign pready  = psel && penable && (wait_left == 2'd0);
  assign prdata  = paddr ^ pattern;                  // Contents follow the whole address
  assign pslverr = pready && (paddr >= err_base);    // Error window at the top of memory

  // One thread draws every wait count, so the sequence is fixed by the seed
  initial begin
    wait_left <= 2'd0;
    void'($urandom(seed));
    forever begin
      @(posedge global_bus);
      if (psel && !penable) begin
        wait_left <= 2'($urandom % 4);  // 0 to 3 stall cycles for this transfer
      end else if (psel && penable && (wait_left != 2'd0)) begin
        wait_left <= wait_left - 2'd1;
      end
    end
  end

endmodule

// File: verification/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
  output logic global_bus,
  output logic rst
);

  localparam int half_period = 20;   // 40 ns clock
  localparam int reset_cycles = 16;

  initial begin
    global_bus = 1'b0;
    forever #half_period global_bus = ~global_bus;
  end

  initial begin
    rst = 1'b1;
    repeat (reset_cycles) @(posedge global_bus);
    rst <= 1'b0;  // Released on a rising edge like any other input
  end

endmodule

// File: design/icache_top.sv
`timescale 1ns/1ps

module icache_top
  import icache_pkg::*;
(
  input  logic            global_bus,
  input  logic            rst,
  input  logic            req_0,
  input  logic [xlen-1:0] addr_0,
  output logic            ready_0,
  output logic            resp_valid_0,
  output logic [xlen-1:0] instr_0,
  output logic            resp_err_0,
  input  logic            req_1,
  input  logic [xlen-1:0] addr_1,
  output logic            ready_1,
  output logic            resp_valid_1,
  output logic [xlen-1:0] instr_1,
  output logic            resp_err_1,
  output logic            psel,
  output logic            penable,
  output logic [xlen-1:0] paddr,
  input  logic [xlen-1:0] prdata,
  input  logic            pready,
  input  logic            pslverr
);

  // **********************************************************
  // Lookup to refill wiring
  // **********************************************************

  logic [set_bits-1:0]  rd_index_0;
  logic [word_bits-1:0] rd_offset_0;
  logic [tag_bits-1:0]  rd_tag_0;
  logic                 rd_valid_0;
  logic [xlen-1:0]      rd_word_0;
  logic                 miss_req_0;
  logic [xlen-1:0]      miss_addr_0;
  logic                 fill_done_0;
  logic                 fill_err_0;
  logic [set_bits-1:0]  rd_index_1;
  logic [word_bits-1:0] rd_offset_1;
  logic [tag_bits-1:0]  rd_tag_1;
  logic                 rd_valid_1;
  logic [xlen-1:0]      rd_word_1;
  logic                 miss_req_1;
  logic [xlen-1:0]      miss_addr_1;
  logic                 fill_done_1;
  logic                 fill_err_1;

  icache_lookup i_lookup_0 (
    .global_bus (global_bus),
    .rst        (rst),
    .req        (req_0),
    .addr       (addr_0),
    .ready      (ready_0),
    .resp_valid (resp_valid_0),
    .instr      (instr_0),
    .resp_err   (resp_err_0),
    .rd_index   (rd_index_0),
    .rd_offset  (rd_offset_0),
    .rd_tag     (rd_tag_0),
    .rd_valid   (rd_valid_0),
    .rd_word    (rd_word_0),
    .miss_req   (miss_req_0),
    .miss_addr  (miss_addr_0),
    .fill_done  (fill_done_0),
    .fill_err   (fill_err_0)
  );

  icache_lookup i_lookup_1 (
    .global_bus (global_bus),
    .rst        (rst),
    .req        (req_1),
    .addr       (addr_1),
    .ready      (ready_1),
    .resp_valid (resp_valid_1),
    .instr      (instr_1),
    .resp_err   (resp_err_1),
    .rd_index   (rd_index_1),
    .rd_offset  (rd_offset_1),
    .rd_tag     (rd_tag_1),
    .rd_valid   (rd_valid_1),
    .rd_word    (rd_word_1),
    .miss_req   (miss_req_1),
    .miss_addr  (miss_addr_1),
    .fill_done  (fill_done_1),
    .fill_err   (fill_err_1)
  );

  // Shared arrays and the single APB master
  icache_refill i_refill (
    .global_bus  (global_bus),
    .rst         (rst),
    .rd_index_0  (rd_index_0),
    .rd_offset_0 (rd_offset_0),
    .rd_tag_0    (rd_tag_0),
    .rd_valid_0  (rd_valid_0),
    .rd_word_0   (rd_word_0),
    .rd_index_1  (rd_index_1),
    .rd_offset_1 (rd_offset_1),
    .rd_tag_1    (rd_tag_1),
    .rd_valid_1  (rd_valid_1),
    .rd_word_1   (rd_word_1),
    .miss_req_0  (miss_req_0),
    .miss_addr_0 (miss_addr_0),
    .fill_done_0 (fill_done_0),
    .fill_err_0  (fill_err_0),
    .miss_req_1  (miss_req_1),
    .miss_addr_1 (miss_addr_1),
    .fill_done_1 (fill_done_1),
    .fill_err_1  (fill_err_1),
    .psel        (psel),
    .penable     (penable),
    .paddr       (paddr),
    .prdata      (prdata),
    .pready      (pready),
    .pslverr     (pslverr)
  );

endmodule

// File: design/icache_refill.sv
`timescale 1ns/1ps

module icache_refill
  import icache_pkg::*;
(
  input  logic                 global_bus,
  input  logic                 rst,
  input  logic [set_bits-1:0]  rd_index_0,
  input  logic [word_bits-1:0] rd_offset_0,
  output logic [tag_bits-1:0]  rd_tag_0,
  output logic                 rd_valid_0,
  output logic [xlen-1:0]      rd_word_0,
  input  logic [set_bits-1:0]  rd_index_1,
  input  logic [word_bits-1:0] rd_offset_1,
  output logic [tag_bits-1:0]  rd_tag_1,
  output logic                 rd_valid_1,
  output logic [xlen-1:0]      rd_word_1,
  input  logic                 miss_req_0,
  input  logic [xlen-1:0]      miss_addr_0,
  output logic                 fill_done_0,
  output logic                 fill_err_0,
  input  logic                 miss_req_1,
  input  logic [xlen-1:0]      miss_addr_1,
  output logic                 fill_done_1,
  output logic                 fill_err_1,
  output logic                 psel,
  output logic                 penable,
  output logic [xlen-1:0]      paddr,
  input  logic [xlen-1:0]      prdata,
  input  logic                 pready,
  input  logic                 pslverr
);

  // **********************************************************
  // Line storage
  // **********************************************************

  logic [tag_bits-1:0] tag_mem [sets];
  logic [sets-1:0]     valid_mem;
  logic [xlen-1:0]     word_mem [sets][words];
  logic [xlen-1:0]     line_buf [words];  // Words collected from APB

  assign rd_tag_0   = tag_mem[rd_index_0];
  assign rd_valid_0 = valid_mem[rd_index_0];
  assign rd_word_0  = word_mem[rd_index_0][rd_offset_0];
  assign rd_tag_1   = tag_mem[rd_index_1];
  assign rd_valid_1 = valid_mem[rd_index_1];
  assign rd_word_1  = word_mem[rd_index_1][rd_offset_1];

  // **********************************************************
  // Arbitration
  // **********************************************************

  refill_state_e          state;
  logic                   last_grant;  // Port that won the previous round
  logic                   cur_port;    // Port the running refill belongs to
  logic [xlen-1:line_lsb] line_addr;   // Tag and index of the line being fetched
  logic [word_bits-1:0]   word_cnt;
  logic                   err_seen;    // Any pslverr during this line
  logic                   pend_0;
  logic                   pend_1;
  logic                   grant;
  logic [xlen-1:0]        sel_addr;
  logic [set_bits-1:0]    sel_index;
  logic [tag_bits-1:0]    sel_tag;
  logic                   sel_present;
  logic                   start_fill;
  logic [set_bits-1:0]    fill_index;
  logic [tag_bits-1:0]    fill_tag;

  // A miss whose fill_done is showing this cycle is already served
  assign pend_0 = miss_req_0 && !fill_done_0;
  assign pend_1 = miss_req_1 && !fill_done_1;
  assign grant  = (pend_0 && pend_1) ? !last_grant : pend_1;

  assign sel_addr  = grant ? miss_addr_1 : miss_addr_0;
  assign sel_index = sel_addr[line_lsb +: set_bits];
  assign sel_tag   = sel_addr[xlen-1 -: tag_bits];

  // When both ports missed on one line the second finds it filled
  assign sel_present = valid_mem[sel_index] && (tag_mem[sel_index] == sel_tag);
  assign start_fill  = (state == idle) && (pend_0 || pend_1) && !sel_present;

  assign fill_index = line_addr[line_lsb +: set_bits];
  assign fill_tag   = line_addr[xlen-1 -: tag_bits];

  // **********************************************************
  // APB read sequence
  // **********************************************************

  assign psel    = (state == setup) || (state == access);
  assign penable = (state == access);
  assign paddr   = {line_addr, word_cnt, 2'b00};  // Ascending words of the line

  always_ff @(posedge global_bus) begin
    if (rst) begin
      state       <= idle;
      last_grant  <= 1'b1;  // Port 0 goes first after reset
      cur_port    <= 1'b0;
      word_cnt    <= '0;
      err_seen    <= 1'b0;
      valid_mem   <= '0;
      fill_done_0 <= 1'b0;
      fill_done_1 <= 1'b0;
      fill_err_0  <= 1'b0;
      fill_err_1  <= 1'b0;
    end else begin
      fill_done_0 <= 1'b0;
      fill_done_1 <= 1'b0;
      fill_err_0  <= 1'b0;
      fill_err_1  <= 1'b0;
      case (state)
        idle: begin
          if (pend_0 || pend_1) begin
            last_grant <= grant;
            cur_port   <= grant;
            if (sel_present) begin
              fill_done_0 <= !grant;  // Line already present so the port is released
              fill_done_1 <= grant;
            end else begin
              word_cnt <= '0;
              err_seen <= 1'b0;
              state    <= setup;
            end
          end
        end
        setup: state <= access;
        access: begin
          if (pready) begin
            err_seen <= err_seen | pslverr;
            if (word_cnt == word_bits'(words - 1)) begin
              state <= write_line;
            end else begin
              word_cnt <= word_cnt + 1'b1;
              state    <= setup;  // Next transfer follows back to back
            end
          end
        end
        write_line: begin
          if (!err_seen) begin
            valid_mem[fill_index] <= 1'b1;
          end
          fill_done_0 <= !cur_port;
          fill_done_1 <= cur_port;
          fill_err_0  <= !cur_port && err_seen;
          fill_err_1  <= cur_port && err_seen;
          state       <= idle;
        end
        default: state <= idle;
      endcase
    end
  end

  // Data side of the refill
  always_ff @(posedge global_bus) begin
    if (start_fill) begin
      line_addr <= sel_addr[xlen-1:line_lsb];
    end
    if ((state == access) && pready) begin
      line_buf[word_cnt] <= prdata;
    end
    if ((state == write_line) && !err_seen) begin
      tag_mem[fill_index] <= fill_tag;
      for (int w = 0; w < words; w++) begin
        word_mem[fill_index][w] <= line_buf[w];
      end
    end
  end

endmodule

// File: design/icache_lookup.sv
`timescale 1ns/1ps

module icache_lookup
  import icache_pkg::*;
(
  input  logic                 global_bus,
  input  logic                 rst,
  input  logic                 req,
  input  logic [xlen-1:0]      addr,
  output logic                 ready,
  output logic                 resp_valid,
  output logic [xlen-1:0]      instr,
  output logic                 resp_err,
  output logic [set_bits-1:0]  rd_index,
  output logic [word_bits-1:0] rd_offset,
  input  logic [tag_bits-1:0]  rd_tag,
  input  logic                 rd_valid,
  input  logic [xlen-1:0]      rd_word,
  output logic                 miss_req,
  output logic [xlen-1:0]      miss_addr,
  input  logic                 fill_done,
  input  logic                 fill_err
);

  // **********************************************************
  // Port state
  // **********************************************************

  typedef enum logic [1:0] {
    port_idle,       // Ready for a new fetch
    port_lookup,     // First compare against the array
    port_wait_fill,  // Miss raised and waiting for the refill unit
    port_recheck     // Second compare after the line was filled
  } port_state_e;

  port_state_e         state;
  logic [xlen-1:0]     addr_q;  // Address of the fetch in flight
  logic                take;
  logic                compare;
  logic                hit;

  assign take    = (state == port_idle) && ready && req;
  assign compare = (state == port_lookup) || (state == port_recheck);

  // The array read ports follow the held address all the time
  assign rd_index  = addr_q[line_lsb +: set_bits];
  assign rd_offset = addr_q[2 +: word_bits];

  assign hit = rd_valid && (rd_tag == addr_q[xlen-1 -: tag_bits]);

  // **********************************************************
  // Control
  // **********************************************************

  always_ff @(posedge global_bus) begin
    if (rst) begin
      state      <= port_idle;
      ready      <= 1'b1;
      resp_valid <= 1'b0;
      resp_err   <= 1'b0;
      miss_req   <= 1'b0;
    end else begin
      resp_valid <= 1'b0;  // Response is a single cycle pulse
      case (state)
        port_idle: begin
          if (take) begin
            ready <= 1'b0;
            state <= port_lookup;
          end else begin
            ready <= 1'b1;  // Rises the cycle after the response
          end
        end
        port_lookup, port_recheck: begin
          if (hit) begin
            resp_valid <= 1'b1;
            resp_err   <= 1'b0;
            state      <= port_idle;
          end else begin
            miss_req <= 1'b1;  // Held until fill_done
            state    <= port_wait_fill;
          end
        end
        port_wait_fill: begin
          if (fill_done) begin
            miss_req <= 1'b0;
            if (fill_err) begin
              // A bus error is answered at once since the line stays invalid
              resp_valid <= 1'b1;
              resp_err   <= 1'b1;
              state      <= port_idle;
            end else begin
              state <= port_recheck;
            end
          end
        end
        default: state <= port_idle;
      endcase
    end
  end

  // **********************************************************
  // Payload
  // **********************************************************

  always_ff @(posedge global_bus) begin
    if (take) begin
      addr_q <= addr;
    end
    if (compare && hit) begin
      instr <= rd_word;
    end else if ((state == port_wait_fill) && fill_done && fill_err) begin
      instr <= '0;
    end
    miss_addr <= {addr_q[xlen-1:line_lsb], {line_lsb{1'b0}}};  // Line base of the fetch
  end

endmodule

// File: design/icache_pkg.sv
package icache_pkg;

  // **********************************************************
  // Cache geometry
  // **********************************************************

  localparam int xlen = 32;   // Address and data width of one word
  localparam int sets = 8;    // Number of lines in the direct mapped array
  localparam int words = 4;   // Words per line

  // **********************************************************
  // Address fields
  // **********************************************************

  // An address splits into tag, index, word offset and the
  // two ignored byte bits, from the top down
  localparam int set_bits = $clog2(sets);
  localparam int word_bits = $clog2(words);
  localparam int line_lsb = word_bits + 2;                   // Lowest bit of the line base
  localparam int tag_bits = xlen - set_bits - word_bits - 2;

  // **********************************************************
  // Refill engine
  // **********************************************************

  // One APB word read takes a setup and at least one access
  // cycle; the line is written into the arrays after the fourth
  typedef enum logic [1:0] {
    idle,        // Waiting for a miss from either port
    setup,       // APB setup phase with psel high and penable low
    access,      // APB access phase held until pready
    write_line   // Tag, words and valid bit written and the requester told
  } refill_state_e;

endpackage
